// File: design/clint.sv
`timescale 1ns/10ps
`include "periph_config.svh"

module clint (
  input  logic          clk_i,
  input  logic          ndmreset_n,
  reg_bus_if.completer  bus_i,
  output logic          timer_irq_o,
  output logic          ipi_o
);
  import periph_pkg::*;

  logic   tick_q;
  mtime_t mtime_q;
  mtime_t mtimecmp_q;
  logic   msip_q;
  logic   timer_irq_q;
  data_t  rd_data;
  data_t  rdata_q;
  logic   wr;

  assign wr = bus_i.req && bus_i.we;

  always_comb begin
    rd_data = '0;
    case (bus_i.addr)
      `PERIPH_MSIP_OFS:         rd_data = data_t'(msip_q);
      `PERIPH_MTIMECMP_OFS:     rd_data = mtimecmp_q[31:0];
      `PERIPH_MTIMECMP_OFS + 4: rd_data = mtimecmp_q[63:32];
      `PERIPH_MTIME_OFS:        rd_data = mtime_q[31:0];
      `PERIPH_MTIME_OFS + 4:    rd_data = mtime_q[63:32];
      default:                  rd_data = '0;
    endcase
  end

  // --------------------------------------------------
  // Half-rate tick drives mtime
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      tick_q      <= 1'b0;
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      timer_irq_q <= 1'b0;
      rdata_q     <= '0;
    end else begin
      tick_q <= ~tick_q;
      if (!tick_q) mtime_q <= mtime_q + 1'b1;
      timer_irq_q <= (mtime_q >= mtimecmp_q);
      rdata_q     <= (bus_i.req && !bus_i.we) ? rd_data : '0;
      if (wr && bus_i.addr == `PERIPH_MSIP_OFS && bus_i.be[0]) msip_q <= bus_i.wdata[0];
      if (wr && bus_i.addr == `PERIPH_MTIMECMP_OFS) begin
        mtimecmp_q[31:0] <= apply_be(mtimecmp_q[31:0], bus_i.wdata, bus_i.be);
      end
      if (wr && bus_i.addr == `PERIPH_MTIMECMP_OFS + 4) begin
        mtimecmp_q[63:32] <= apply_be(mtimecmp_q[63:32], bus_i.wdata, bus_i.be);
      end
    end
  end

  assign bus_i.rdata = rdata_q;
  assign timer_irq_o = timer_irq_q;
  assign ipi_o       = msip_q;

  // Disarmed compare drops the timer line
  a_cmp_disarm: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (mtimecmp_q == '1) |=> !timer_irq_o);

endmodule

// File: design/periph_config.svh
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// Address map
`define PERIPH_CLINT_BASE   32'h0200_0000
`define PERIPH_CLINT_LENGTH 32'h000C_0000
`define PERIPH_PLIC_BASE    32'h0C00_0000
`define PERIPH_PLIC_LENGTH  32'h0400_0000

// 64-bit CLINT registers sit as low word then high word
`define PERIPH_MSIP_OFS     32'h0000_0000
`define PERIPH_MTIMECMP_OFS 32'h0000_4000
`define PERIPH_MTIME_OFS    32'h0000_BFF8

// PLIC offsets
`define PERIPH_PRIO_OFS     32'h0000_0000
`define PERIPH_PENDING_OFS  32'h0000_1000
`define PERIPH_ENABLE_OFS   32'h0000_2000
`define PERIPH_CONTEXT_OFS  32'h0020_0000

// PLIC sizes
`define PERIPH_NUM_SOURCES  32
`define PERIPH_NUM_TARGETS  2
`define PERIPH_MAX_PRIO     7

`endif

// File: design/periph_pkg.sv
package periph_pkg;

  `include "periph_config.svh"

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [63:0] mtime_t;

  typedef logic [$clog2(`PERIPH_MAX_PRIO+1)-1:0] prio_t;
  typedef logic [$clog2(`PERIPH_NUM_SOURCES)-1:0] src_id_t;
  typedef logic [`PERIPH_NUM_SOURCES-1:0] src_vec_t;

  typedef enum logic [1:0] {
    REGION_NONE,
    REGION_CLINT,
    REGION_PLIC
  } region_e;

  // Byte-masked register update
  function automatic data_t apply_be(data_t cur, data_t wdata, strb_t be);
    data_t res;
    res = cur;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (be[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

endpackage

// File: design/periph_top.sv
`timescale 1ns/10ps
`include "periph_config.svh"

module periph_top (
  input  logic                            clk_i,
  input  logic                            ndmreset_n,
  input  logic                            req_i,
  input  logic                            we_i,
  input  periph_pkg::addr_t               addr_i,
  input  periph_pkg::strb_t               be_i,
  input  periph_pkg::data_t               wdata_i,
  output periph_pkg::data_t               rdata_o,
  input  periph_pkg::src_vec_t            irq_sources_i,
  output logic                            timer_irq_o,
  output logic                            ipi_o,
  output logic [`PERIPH_NUM_TARGETS-1:0]  eip_o
);

  reg_bus_if clint_bus ();
  reg_bus_if plic_bus ();

  reg_bus_decoder u_decoder (
    .clk_i      (clk_i),
    .ndmreset_n (ndmreset_n),
    .req_i      (req_i),
    .we_i       (we_i),
    .addr_i     (addr_i),
    .be_i       (be_i),
    .wdata_i    (wdata_i),
    .rdata_o    (rdata_o),
    .clint_o    (clint_bus),
    .plic_o     (plic_bus)
  );

  clint u_clint (
    .clk_i       (clk_i),
    .ndmreset_n  (ndmreset_n),
    .bus_i       (clint_bus),
    .timer_irq_o (timer_irq_o),
    .ipi_o       (ipi_o)
  );

  plic u_plic (
    .clk_i         (clk_i),
    .ndmreset_n    (ndmreset_n),
    .bus_i         (plic_bus),
    .irq_sources_i (irq_sources_i),
    .eip_o         (eip_o)
  );

endmodule

// File: design/plic.sv
`timescale 1ns/10ps
`include "periph_config.svh"

module plic (
  input  logic                            clk_i,
  input  logic                            ndmreset_n,
  reg_bus_if.completer                    bus_i,
  input  periph_pkg::src_vec_t            irq_sources_i,
  output logic [`PERIPH_NUM_TARGETS-1:0]  eip_o
);
  import periph_pkg::*;

  localparam int    NS             = `PERIPH_NUM_SOURCES;
  localparam int    NT             = `PERIPH_NUM_TARGETS;
  localparam addr_t ENABLE_STRIDE  = 32'h80;
  localparam addr_t CONTEXT_STRIDE = 32'h1000;

  prio_t    [NS-1:0] prio_q;
  src_vec_t [NT-1:0] enable_q;
  prio_t    [NT-1:0] threshold_q;
  src_id_t  [NT-1:0] claim_ids;
  src_vec_t          pending;
  addr_t             prio_ofs;
  logic              prio_hit;
  src_id_t           prio_idx;
  logic     [NT-1:0] en_hit, thr_hit, clm_hit;
  data_t             rd_data, rdata_q;
  src_id_t           claim_id;
  logic              claim, complete;

  // --------------------------------------------------
  // Offset decode and read mux
  always_comb begin
    prio_ofs = bus_i.addr - `PERIPH_PRIO_OFS;
    prio_hit = prio_ofs < addr_t'(4 * NS);
    prio_idx = prio_ofs[2 +: $bits(src_id_t)];
    rd_data  = '0;
    claim_id = '0;
    if (prio_hit) rd_data = data_t'(prio_q[prio_idx]);
    if (bus_i.addr == `PERIPH_PENDING_OFS) rd_data = pending;
    for (int t = 0; t < NT; t++) begin
      en_hit[t]  = bus_i.addr == `PERIPH_ENABLE_OFS + ENABLE_STRIDE * addr_t'(t);
      thr_hit[t] = bus_i.addr == `PERIPH_CONTEXT_OFS + CONTEXT_STRIDE * addr_t'(t);
      clm_hit[t] = bus_i.addr == `PERIPH_CONTEXT_OFS + CONTEXT_STRIDE * addr_t'(t) + 4;
      if (en_hit[t]) rd_data = enable_q[t];
      if (thr_hit[t]) rd_data = data_t'(threshold_q[t]);
      if (clm_hit[t]) begin
        rd_data  = data_t'(claim_ids[t]);
        claim_id = claim_ids[t];
      end
    end
  end

  assign claim    = bus_i.req && !bus_i.we && |clm_hit;
  assign complete = bus_i.req && bus_i.we && |clm_hit;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      prio_q      <= '0;
      enable_q    <= '0;
      threshold_q <= '0;
      rdata_q     <= '0;
    end else begin
      rdata_q <= (bus_i.req && !bus_i.we) ? rd_data : '0;
      if (bus_i.req && bus_i.we) begin
        // Source 0 keeps priority zero
        if (prio_hit && prio_idx != '0 && bus_i.be[0]) prio_q[prio_idx] <= prio_t'(bus_i.wdata);
        for (int t = 0; t < NT; t++) begin
          if (en_hit[t]) begin
            enable_q[t] <= apply_be(enable_q[t], bus_i.wdata, bus_i.be) & ~src_vec_t'(1);
          end
          if (thr_hit[t] && bus_i.be[0]) threshold_q[t] <= prio_t'(bus_i.wdata);
        end
      end
    end
  end

  assign bus_i.rdata = rdata_q;

  plic_gateway u_gateway (
    .clk_i         (clk_i),
    .ndmreset_n    (ndmreset_n),
    .irq_sources_i (irq_sources_i),
    .claim_i       (claim),
    .claim_id_i    (claim_id),
    .complete_i    (complete),
    .complete_id_i (src_id_t'(bus_i.wdata)),
    .pending_o     (pending)
  );

  for (genvar t = 0; t < NT; t++) begin : g_target
    plic_target u_target (
      .pending_i   (pending),
      .enable_i    (enable_q[t]),
      .prio_i      (prio_q),
      .threshold_i (threshold_q[t]),
      .claim_id_o  (claim_ids[t]),
      .eip_o       (eip_o[t])
    );
  end

endmodule

// File: design/plic_gateway.sv
`timescale 1ns/10ps

module plic_gateway (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  periph_pkg::src_vec_t  irq_sources_i,
  input  logic                  claim_i,
  input  periph_pkg::src_id_t   claim_id_i,
  input  logic                  complete_i,
  input  periph_pkg::src_id_t   complete_id_i,
  output periph_pkg::src_vec_t  pending_o
);
  import periph_pkg::*;

  // Line 0 is reserved
  localparam src_vec_t SRC_MASK = ~src_vec_t'(1);

  src_vec_t pending_q, inflight_q;
  src_vec_t claim_mask, complete_mask;

  always_comb begin
    claim_mask    = '0;
    complete_mask = '0;
    if (claim_i) claim_mask[claim_id_i] = 1'b1;
    if (complete_i) complete_mask[complete_id_i] = 1'b1;
  end

  // Level sources pend again only once the handler completes
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      pending_q  <= '0;
      inflight_q <= '0;
    end else begin
      pending_q  <= (pending_q | (irq_sources_i & ~inflight_q)) & ~claim_mask & SRC_MASK;
      inflight_q <= (inflight_q | claim_mask) & ~complete_mask & SRC_MASK;
    end
  end

  assign pending_o = pending_q;

  a_no_overlap: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (pending_q & inflight_q) == '0);

endmodule

// File: design/plic_target.sv
`timescale 1ns/10ps
`include "periph_config.svh"

module plic_target (
  input  periph_pkg::src_vec_t                           pending_i,
  input  periph_pkg::src_vec_t                           enable_i,
  input  periph_pkg::prio_t [`PERIPH_NUM_SOURCES-1:0]    prio_i,
  input  periph_pkg::prio_t                              threshold_i,
  output periph_pkg::src_id_t                            claim_id_o,
  output logic                                           eip_o
);
  import periph_pkg::*;

  src_vec_t active;
  prio_t    best_prio;
  src_id_t  best_id;

  assign active = pending_i & enable_i;

  // --------------------------------------------------
  // Strict compare keeps the lowest id on ties
  always_comb begin
    best_prio = threshold_i;
    best_id   = '0;
    for (int i = 1; i < `PERIPH_NUM_SOURCES; i++) begin
      if (active[i] && prio_i[i] > best_prio) begin
        best_prio = prio_i[i];
        best_id   = src_id_t'(i);
      end
    end
  end

  assign claim_id_o = best_id;
  assign eip_o      = (best_id != '0);

endmodule

// File: design/reg_bus_decoder.sv
`timescale 1ns/10ps
`include "periph_config.svh"

module reg_bus_decoder (
  input  logic                clk_i,
  input  logic                ndmreset_n,
  input  logic                req_i,
  input  logic                we_i,
  input  periph_pkg::addr_t   addr_i,
  input  periph_pkg::strb_t   be_i,
  input  periph_pkg::data_t   wdata_i,
  output periph_pkg::data_t   rdata_o,
  reg_bus_if.requester        clint_o,
  reg_bus_if.requester        plic_o
);
  import periph_pkg::*;

  localparam addr_t CLINT_END = `PERIPH_CLINT_BASE + `PERIPH_CLINT_LENGTH;
  localparam addr_t PLIC_END  = `PERIPH_PLIC_BASE + `PERIPH_PLIC_LENGTH;

  region_e region;
  region_e rd_region_q;

  always_comb begin
    region = REGION_NONE;
    if (addr_i >= `PERIPH_CLINT_BASE && addr_i < CLINT_END) begin
      region = REGION_CLINT;
    end else if (addr_i >= `PERIPH_PLIC_BASE && addr_i < PLIC_END) begin
      region = REGION_PLIC;
    end
  end

  // Request fan-out with region-relative addresses
  assign clint_o.req   = req_i && (region == REGION_CLINT);
  assign clint_o.we    = we_i;
  assign clint_o.addr  = addr_i - `PERIPH_CLINT_BASE;
  assign clint_o.be    = be_i;
  assign clint_o.wdata = wdata_i;

  assign plic_o.req    = req_i && (region == REGION_PLIC);
  assign plic_o.we     = we_i;
  assign plic_o.addr   = addr_i - `PERIPH_PLIC_BASE;
  assign plic_o.be     = be_i;
  assign plic_o.wdata  = wdata_i;

  // --------------------------------------------------
  // Read return path
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rd_region_q <= REGION_NONE;
    end else begin
      rd_region_q <= (req_i && !we_i) ? region : REGION_NONE;
    end
  end

  always_comb begin
    case (rd_region_q)
      REGION_CLINT: rdata_o = clint_o.rdata;
      REGION_PLIC:  rdata_o = plic_o.rdata;
      default:      rdata_o = '0;
    endcase
  end

  a_one_completer: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !(clint_o.req && plic_o.req));

endmodule

// File: design/reg_bus_if.sv
`timescale 1ns/10ps

interface reg_bus_if;
  import periph_pkg::*;

  logic  req;
  logic  we;
  addr_t addr;
  strb_t be;
  data_t wdata;
  data_t rdata;

  modport requester (
    output req, we, addr, be, wdata,
    input  rdata
  );

  // Completers answer reads one cycle after the request
  modport completer (
    input  req, we, addr, be, wdata,
    output rdata
  );

endinterface

// File: periph_subsys.f
+incdir+design
design/periph_pkg.sv
design/reg_bus_if.sv
design/plic_target.sv
design/plic_gateway.sv
design/plic.sv
design/clint.sv
design/reg_bus_decoder.sv
design/periph_top.sv
sim/tb_periph_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_periph_top -f periph_subsys.f \
  && ./obj_dir/Vtb_periph_top | tee /dev/stderr | grep -qx "Everything OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: sim/tb_periph_top.sv
`timescale 1ns/10ps
`include "periph_config.svh"

module tb_periph_top;
  import periph_pkg::*;

  localparam int NS         = `PERIPH_NUM_SOURCES;
  localparam int CLK_PERIOD = 100;
  // Cycle budget of each test section
  localparam int RESET_CYCLES    = 3;
  localparam int CLINT_CYCLES    = 400;
  localparam int PLIC_CYCLES     = 6 * NS + 100;
  localparam int THRESH_CYCLES   = 100;
  localparam int WATCHDOG_CYCLES =
    2 * (RESET_CYCLES + CLINT_CYCLES + PLIC_CYCLES + THRESH_CYCLES);

  localparam addr_t MSIP_ADDR     = `PERIPH_CLINT_BASE + `PERIPH_MSIP_OFS;
  localparam addr_t MTIMECMP_LO   = `PERIPH_CLINT_BASE + `PERIPH_MTIMECMP_OFS;
  localparam addr_t MTIMECMP_HI   = MTIMECMP_LO + 4;
  localparam addr_t MTIME_LO      = `PERIPH_CLINT_BASE + `PERIPH_MTIME_OFS;
  localparam addr_t PRIO_BASE     = `PERIPH_PLIC_BASE + `PERIPH_PRIO_OFS;
  localparam addr_t PENDING_ADDR  = `PERIPH_PLIC_BASE + `PERIPH_PENDING_OFS;
  localparam addr_t ENABLE0       = `PERIPH_PLIC_BASE + `PERIPH_ENABLE_OFS;
  localparam addr_t ENABLE1       = ENABLE0 + 32'h80;
  localparam addr_t THRESH0       = `PERIPH_PLIC_BASE + `PERIPH_CONTEXT_OFS;
  localparam addr_t CLAIM0        = THRESH0 + 4;
  localparam addr_t THRESH1       = THRESH0 + 32'h1000;
  localparam addr_t UNMAPPED_ADDR = 32'h1000_0000;

  logic                           clk_i;
  logic                           ndmreset_n;
  logic                           req_i;
  logic                           we_i;
  addr_t                          addr_i;
  strb_t                          be_i;
  data_t                          wdata_i;
  data_t                          rdata_o;
  src_vec_t                       irq_sources_i;
  logic                           timer_irq_o;
  logic                           ipi_o;
  logic [`PERIPH_NUM_TARGETS-1:0] eip_o;

  int    errors = 0;
  int    seed   = 32'h1bf26670;
  time   req_time;
  logic  t0_quiet;
  logic  t1_quiet;
  prio_t prio_model [NS];

  periph_top u_dut (
    .clk_i         (clk_i),
    .ndmreset_n    (ndmreset_n),
    .req_i         (req_i),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .be_i          (be_i),
    .wdata_i       (wdata_i),
    .rdata_o       (rdata_o),
    .irq_sources_i (irq_sources_i),
    .timer_irq_o   (timer_irq_o),
    .ipi_o         (ipi_o),
    .eip_o         (eip_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests finished, errors: %0d", errors);
    $display("Something failed");
    $finish;
  end

  // --------------------------------------------------
  // Helpers
  function automatic logic in_map(input addr_t a);
    return (a >= `PERIPH_CLINT_BASE && a - `PERIPH_CLINT_BASE < `PERIPH_CLINT_LENGTH) ||
           (a >= `PERIPH_PLIC_BASE && a - `PERIPH_PLIC_BASE < `PERIPH_PLIC_LENGTH);
  endfunction

  // Scan from the top priority down, lowest id first within a level
  function automatic src_id_t best_source(input src_vec_t set, input prio_t thr);
    src_id_t id;
    logic    found;
    id    = '0;
    found = 1'b0;
    for (int p = `PERIPH_MAX_PRIO; p > int'(thr); p--) begin
      for (int i = 1; i < NS; i++) begin
        if (!found && set[i] && int'(prio_model[i]) == p) begin
          id    = src_id_t'(i);
          found = 1'b1;
        end
      end
    end
    return id;
  endfunction

  task automatic write_reg(input addr_t addr, input data_t data);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= 1'b1;
    addr_i  <= addr;
    be_i    <= '1;
    wdata_i <= data;
    @(posedge clk_i);
    req_i <= 1'b0;
    we_i  <= 1'b0;
  endtask

  task automatic read_reg(input addr_t addr, output data_t data);
    @(posedge clk_i);
    req_time = $time;
    req_i  <= 1'b1;
    we_i   <= 1'b0;
    addr_i <= addr;
    @(posedge clk_i);
    req_i <= 1'b0;
    @(negedge clk_i);
    data = rdata_o;
  endtask

  task automatic compare_value(input data_t got, input data_t exp, input string what);
    assert (got == exp) else begin
      errors++;
      $display("mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic wait_eip(input int tgt, input logic level, input int max_cycles);
    int n;
    n = 0;
    while (eip_o[tgt] !== level && n < max_cycles) begin
      @(negedge clk_i);
      n++;
    end
    if (eip_o[tgt] !== level) begin
      errors++;
      $display("eip_o[%0d] did not go to %0b within %0d cycles", tgt, level, max_cycles);
    end
  endtask

  // --------------------------------------------------
  // Checks
  a_ipi_follows: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (req_i && we_i && be_i[0] && addr_i == MSIP_ADDR) |=> (ipi_o == $past(wdata_i[0])))
    else begin
      errors++;
      $display("mismatch at %0t: ipi_o does not follow the msip write", $time);
    end

  a_unmapped_zero: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (req_i && !we_i && !in_map(addr_i)) |=> (rdata_o == '0))
    else begin
      errors++;
      $display("mismatch at %0t: unmapped read returned 0x%0h", $time, rdata_o);
    end

  a_t0_quiet: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    t0_quiet |-> !eip_o[0])
    else begin
      errors++;
      $display("mismatch at %0t: eip_o[0] high with threshold at maximum", $time);
    end

  a_t1_quiet: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    t1_quiet |-> !eip_o[1])
    else begin
      errors++;
      $display("mismatch at %0t: eip_o[1] high from sources it does not enable", $time);
    end

  initial begin
    data_t    rd;
    data_t    m0;
    time      t0;
    int       cycles;
    int       polls;
    logic     timer_done;
    src_vec_t en0;
    src_vec_t src;
    src_vec_t remaining;
    src_id_t  exp_id;
    src_id_t  first_id;
    src_id_t  claimed[$];

    ndmreset_n    = 1'b0;
    req_i         = 1'b0;
    we_i          = 1'b0;
    addr_i        = '0;
    be_i          = '0;
    wdata_i       = '0;
    irq_sources_i = '0;
    t0_quiet      = 1'b0;
    t1_quiet      = 1'b1;
    prio_model[0] = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    ndmreset_n <= 1'b1;

    // Reset state and mtime rate
    @(negedge clk_i);
    compare_value(data_t'({timer_irq_o, ipi_o, eip_o}), '0, "irq outputs after reset");
    read_reg(MTIME_LO, m0);
    t0 = req_time;
    repeat (20) @(posedge clk_i);
    read_reg(MTIME_LO, rd);
    cycles = int'((req_time - t0) / CLK_PERIOD);
    assert (int'(rd - m0) >= cycles / 2 - 1 && int'(rd - m0) <= cycles / 2 + 1) else begin
      errors++;
      $display("mismatch at %0t: mtime moved %0d in %0d cycles", $time, rd - m0, cycles);
    end

    // Software interrupt and unmapped space
    write_reg(MSIP_ADDR, 32'h1);
    read_reg(MSIP_ADDR, rd);
    compare_value(rd, 32'h1, "msip");
    write_reg(MSIP_ADDR, 32'h0);
    @(negedge clk_i);
    compare_value(data_t'(ipi_o), '0, "ipi_o after clear");
    write_reg(UNMAPPED_ADDR, 32'hdead_beef);
    read_reg(UNMAPPED_ADDR, rd);
    read_reg(`PERIPH_CLINT_BASE + 32'h8, rd);
    compare_value(rd, '0, "unused CLINT offset");

    // Timer compare
    read_reg(MTIME_LO, m0);
    write_reg(MTIMECMP_LO, m0 + 16);
    write_reg(MTIMECMP_HI, 32'h0);
    polls      = 0;
    timer_done = 1'b0;
    while (!timer_done && polls < 60) begin
      read_reg(MTIME_LO, rd);
      if (rd < m0 + 16) compare_value(data_t'(timer_irq_o), '0, "timer_irq_o before compare");
      if (rd >= m0 + 16) begin
        compare_value(data_t'(timer_irq_o), 32'h1, "timer_irq_o at compare");
        timer_done = 1'b1;
      end
      polls++;
    end
    if (!timer_done) begin
      errors++;
      $display("mtime never reached the compare value");
    end
    write_reg(MTIMECMP_HI, '1);
    @(posedge clk_i);
    @(negedge clk_i);
    compare_value(data_t'(timer_irq_o), '0, "timer_irq_o after disarm");
    write_reg(MTIMECMP_LO, '1);

    // --------------------------------------------------
    // PLIC claim order on target 0
    for (int i = 1; i < NS; i++) begin
      prio_model[i] = prio_t'(1 + ({$random(seed)} % `PERIPH_MAX_PRIO));
      write_reg(PRIO_BASE + addr_t'(4 * i), data_t'(prio_model[i]));
    end
    en0 = src_vec_t'($random(seed)) | 32'h100;
    en0[0] = 1'b0;
    src = src_vec_t'($random(seed)) | 32'h100;
    src[0] = 1'b0;
    write_reg(ENABLE0, en0);
    write_reg(THRESH0, 32'h0);
    @(posedge clk_i);
    irq_sources_i <= src;
    wait_eip(0, 1'b1, 10);
    remaining = src & en0;
    while (remaining != '0) begin
      exp_id = best_source(remaining, '0);
      read_reg(CLAIM0, rd);
      compare_value(rd, data_t'(exp_id), "claim id");
      remaining[exp_id] = 1'b0;
      claimed.push_back(exp_id);
    end
    compare_value(data_t'(eip_o[0]), '0, "eip_o[0] after all claims");
    read_reg(CLAIM0, rd);
    compare_value(rd, '0, "claim id with nothing pending");

    // Held source pends again only after complete
    first_id = claimed[0];
    read_reg(PENDING_ADDR, rd);
    compare_value(data_t'(rd[first_id]), '0, "pending bit of claimed source");
    write_reg(CLAIM0, data_t'(first_id));
    read_reg(PENDING_ADDR, rd);
    compare_value(data_t'(rd[first_id]), 32'h1, "pending bit after complete");
    compare_value(data_t'(eip_o[0]), 32'h1, "eip_o[0] after complete");
    @(posedge clk_i);
    irq_sources_i <= '0;
    read_reg(CLAIM0, rd);
    compare_value(rd, data_t'(first_id), "claim id after complete");
    foreach (claimed[i]) write_reg(CLAIM0, data_t'(claimed[i]));

    // --------------------------------------------------
    // Threshold and per-target enable
    write_reg(THRESH0, `PERIPH_MAX_PRIO);
    @(posedge clk_i);
    t0_quiet <= 1'b1;
    write_reg(ENABLE1, ~src & ~src_vec_t'(1));
    write_reg(THRESH1, 32'h0);
    @(posedge clk_i);
    irq_sources_i <= src;
    repeat (10) @(posedge clk_i);
    t0_quiet <= 1'b0;
    write_reg(THRESH0, 32'h0);
    wait_eip(0, 1'b1, 10);
    repeat (4) @(posedge clk_i);
    t1_quiet <= 1'b0;
    @(posedge clk_i);

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
